// ==== project.f ====
+incdir+verif
common/nocPkg.sv
inputBuffer/flitQueue.sv
arbiter/holdTimer.sv
arbiter/portArbiter.sv
logic/arbConfig.sv
logic/routerOutputPort.sv
verif/routerTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the router output port testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module routerTb -f project.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOutput=$(./obj_dir/VrouterTb)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOutput" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

// ==== verif/tbModel.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0] rngState = 32'd18123;
int errors = 0;
int totalFlits = 0;

// Flits still at each source, and flits accepted but not yet seen at the output
flit_t srcQ [NUM_PORTS][$];
flit_t expQ [NUM_PORTS][$];

function automatic logic [31:0] xorshift();
  logic [31:0] x;
  x = rngState;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rngState = x;
  return x;
endfunction

task automatic compare(string name, logic [31:0] actual, logic [31:0] expected);
  if (actual !== expected)
  begin
    $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
    errors++;
  end
endtask

// One head with a hold length of 1 to 8, up to three bodies, one tail
task automatic makePacket(int p);
  logic [31:0] r;
  int len;
  int bodies;
  flit_t f;
  r = xorshift();
  len = int'(r % 32'd8) + 1;
  bodies = int'((r >> 8) % 32'd4);
  f.kind = HEAD;
  f.payload = {r[23:16], 8'(len)};
  srcQ[p].push_back(f);
  for (int i = 0; i < bodies; i++)
  begin
    r = xorshift();
    f.kind = BODY;
    f.payload = r[15:0];
    srcQ[p].push_back(f);
  end
  r = xorshift();
  f.kind = TAIL;
  f.payload = r[15:0];
  srcQ[p].push_back(f);
  totalFlits += bodies + 2;
endtask

function automatic logic drained(logic [NUM_PORTS-1:0] mask);
  logic empty;
  empty = 1'b1;
  for (int p = 0; p < NUM_PORTS; p++)
  begin
    if (mask[p] && (srcQ[p].size() != 0 || expQ[p].size() != 0))
      empty = 1'b0;
  end
  return empty;
endfunction

function automatic logic allSourcesBusy();
  logic busy;
  busy = 1'b1;
  for (int p = 0; p < NUM_PORTS; p++)
  begin
    if (srcQ[p].size() == 0)
      busy = 1'b0;
  end
  return busy;
endfunction

`endif

// ==== verif/routerTb.sv ====
module routerTb
  import nocPkg::*;
();

  `include "tbModel.svh"

  logic clk = 1'b0;
  logic rst;
  logic [NUM_PORTS-1:0] inValid;
  flit_t inFlit [NUM_PORTS];
  logic [NUM_PORTS-1:0] inReady;
  logic outValid;
  outFlit_t outFlit;
  logic outReady;
  logic cfgWe;
  cfgAddr_t cfgAddr;
  logic [HOLD_W-1:0] cfgData;

  logic saturate = 1'b0;
  logic backPressure = 1'b0;
  logic [NUM_PORTS-1:0] acc = '0;
  logic [NUM_PORTS-1:0] tbMask = '1;
  int tbMaxHold = 8;
  int lastLimit [NUM_PORTS] = '{default: 8};
  int lastSrc = -1;
  logic lastTail = 1'b0;
  int runLen = 0;
  logic holdPending = 1'b0;
  outFlit_t heldFlit;
  int passCount = 0;
  int failCount = 0;

  always #10 clk = ~clk;

  routerOutputPort dut_i (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlit   (inFlit),
    .inReady  (inReady),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outReady (outReady),
    .cfgWe    (cfgWe),
    .cfgAddr  (cfgAddr),
    .cfgData  (cfgData)
  );

  // ####################
  // Sources
  // ####################

  task automatic driveSources();
    logic [31:0] r;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (acc[p])
        void'(srcQ[p].pop_front());
      // An offered flit that was not taken stays on the wires
      if (!inValid[p] || acc[p])
      begin
        r = xorshift();
        inValid[p] = (srcQ[p].size() != 0) && (saturate || r[1:0] != 2'b00);
        if (srcQ[p].size() != 0)
          inFlit[p] = srcQ[p][0];
      end
    end
    r = xorshift();
    outReady = !backPressure || (r[3:2] != 2'b00);
  endtask

  initial
  begin
    inValid = '0;
    for (int p = 0; p < NUM_PORTS; p++)
      inFlit[p] = '0;
    outReady = 1'b1;
    forever
    begin
      @(posedge clk);
      #1;
      driveSources();
    end
  end

  // ####################
  // Monitor
  // ####################

  task automatic checkOutput();
    int src;
    int limit;
    flit_t expFlit;
    src = int'(outFlit.src);
    if (!tbMask[src])
    begin
      $display("ERROR at %0t: output carries flit of masked port %0d", $time, src);
      errors++;
    end
    if (expQ[src].size() == 0)
    begin
      $display("ERROR at %0t: port %0d sent a flit that was never accepted", $time, src);
      errors++;
    end
    else
    begin
      expFlit = expQ[src].pop_front();
      compare($sformatf("outFlit.flit port %0d", src), 32'(outFlit.flit), 32'(expFlit));
    end
    if (outFlit.flit.kind == HEAD)
    begin
      limit = int'(outFlit.flit.payload[HOLD_W-1:0]);
      lastLimit[src] = (limit < tbMaxHold) ? limit : tbMaxHold;
    end
    runLen = (src == lastSrc) ? runLen + 1 : 1;
    // Only meaningful while every port still has traffic waiting
    if (saturate && allSourcesBusy())
    begin
      if (runLen > lastLimit[src])
      begin
        $display("ERROR at %0t: port %0d held the output for %0d flits, limit is %0d",
                 $time, src, runLen, lastLimit[src]);
        errors++;
      end
      if (lastTail && src == lastSrc)
      begin
        $display("ERROR at %0t: port %0d kept the output after its tail flit", $time, src);
        errors++;
      end
    end
    lastSrc = src;
    lastTail = (outFlit.flit.kind == TAIL);
  endtask

  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (holdPending)
      begin
        compare("outValid", 32'(outValid), 32'd1);
        compare("outFlit", 32'(outFlit), 32'(heldFlit));
      end
      holdPending = outValid && !outReady;
      heldFlit = outFlit;
      if (outValid && outReady)
        checkOutput();
      acc = inValid & inReady;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        if (acc[p])
          expQ[p].push_back(inFlit[p]);
      end
    end
  end

  // ####################
  // Test sequence
  // ####################

  task automatic settle();
    @(posedge clk);
    #5;
  endtask

  task automatic writeCfg(cfgAddr_t addr, logic [HOLD_W-1:0] data);
    @(posedge clk);
    #1;
    cfgWe = 1'b1;
    cfgAddr = addr;
    cfgData = data;
    @(posedge clk);
    #1;
    cfgWe = 1'b0;
    if (addr == CFG_MASK)
      tbMask = data[NUM_PORTS-1:0];
    else
      tbMaxHold = (data == '0) ? 1 : int'(data);
  endtask

  task automatic fillPorts(int packets);
    for (int k = 0; k < packets; k++)
    begin
      for (int p = 0; p < NUM_PORTS; p++)
        makePacket(p);
    end
  endtask

  task automatic waitDrained(logic [NUM_PORTS-1:0] mask);
    while (!drained(mask))
      settle();
  endtask

  task automatic finishTest(string name, int errorsBefore);
    if (errors == errorsBefore)
    begin
      passCount++;
      $display("test %s: ok", name);
    end
    else
    begin
      failCount++;
      $display("test %s: failed with %0d errors", name, errors - errorsBefore);
    end
  endtask

  initial
  begin
    int mark;
    rst = 1'b1;
    cfgWe = 1'b0;
    cfgAddr = CFG_MASK;
    cfgData = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    mark = errors;
    @(negedge clk);
    compare("outValid", 32'(outValid), 32'd0);
    compare("inReady", 32'(inReady), 32'({NUM_PORTS{1'b1}}));
    finishTest("reset state", mark);

    mark = errors;
    settle();
    backPressure = 1'b1;
    fillPorts(8);
    waitDrained('1);
    finishTest("random traffic with back-pressure", mark);

    // East masked, its backlog must come out in order once enabled again
    mark = errors;
    writeCfg(CFG_MASK, 8'h1b);
    settle();
    fillPorts(4);
    waitDrained(5'b11011);
    repeat (10) settle();
    compare("flits queued on masked port", 32'(expQ[PORT_E].size() != 0), 32'd1);
    writeCfg(CFG_MASK, 8'h1f);
    waitDrained('1);
    finishTest("port mask", mark);

    mark = errors;
    writeCfg(CFG_HOLD, 8'd3);
    settle();
    lastSrc = -1;
    lastTail = 1'b0;
    saturate = 1'b1;
    fillPorts(10);
    waitDrained('1);
    saturate = 1'b0;
    finishTest("hold limit and tail", mark);

    $display("tests passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0 && errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= 40 * totalFlits + 200)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("ERROR: the run timed out after %0d cycles", cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== logic/routerOutputPort.sv ====
module routerOutputPort
  import nocPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [NUM_PORTS-1:0] inValid,
  input  flit_t                inFlit [NUM_PORTS],
  output logic [NUM_PORTS-1:0] inReady,
  output logic                 outValid,
  output outFlit_t             outFlit,
  input  logic                 outReady,
  input  logic                 cfgWe,
  input  cfgAddr_t             cfgAddr,
  input  logic [HOLD_W-1:0]    cfgData
);

  logic [NUM_PORTS-1:0] qValid;
  logic [NUM_PORTS-1:0] qReady;
  flit_t qFlit [NUM_PORTS];
  logic [NUM_PORTS-1:0] timesUp;
  logic [NUM_PORTS-1:0] holdRun;
  logic [NUM_PORTS-1:0] holdClear;
  logic [NUM_PORTS-1:0] headSeen;
  logic [HOLD_W-1:0] headLength;
  arbCfg_t cfg;

  // Per-input queue and hold timer
  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : gPort
    flitQueue queue_i (
      .clk     (clk),
      .rst     (rst),
      .inValid (inValid[p]),
      .inFlit  (inFlit[p]),
      .inReady (inReady[p]),
      .qValid  (qValid[p]),
      .qFlit   (qFlit[p]),
      .qReady  (qReady[p])
    );

    holdTimer timer_i (
      .clk        (clk),
      .rst        (rst),
      .headSeen   (headSeen[p]),
      .headLength (headLength),
      .maxHold    (cfg.maxHold),
      .holdRun    (holdRun[p]),
      .holdClear  (holdClear[p]),
      .timesUp    (timesUp[p])
    );
  end

  portArbiter arbiter_i (
    .clk        (clk),
    .rst        (rst),
    .cfg        (cfg),
    .qValid     (qValid),
    .qFlit      (qFlit),
    .qReady     (qReady),
    .timesUp    (timesUp),
    .holdRun    (holdRun),
    .holdClear  (holdClear),
    .headSeen   (headSeen),
    .headLength (headLength),
    .outValid   (outValid),
    .outFlit    (outFlit),
    .outReady   (outReady)
  );

  arbConfig config_i (
    .clk     (clk),
    .rst     (rst),
    .cfgWe   (cfgWe),
    .cfgAddr (cfgAddr),
    .cfgData (cfgData),
    .cfg     (cfg)
  );

endmodule

// ==== logic/arbConfig.sv ====
module arbConfig
  import nocPkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              cfgWe,
  input  cfgAddr_t          cfgAddr,
  input  logic [HOLD_W-1:0] cfgData,
  output arbCfg_t           cfg
);

  arbCfg_t cfgReg;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cfgReg.portMask <= '1;
      cfgReg.maxHold <= DEFAULT_HOLD;
    end
    else if (cfgWe)
    begin
      case (cfgAddr)
        CFG_MASK:
          cfgReg.portMask <= cfgData[NUM_PORTS-1:0];
        CFG_HOLD:
        begin
          // A zero hold would stall the grant, keep at least one flit
          if (cfgData == '0)
            cfgReg.maxHold <= HOLD_W'(1);
          else
            cfgReg.maxHold <= cfgData;
        end
      endcase
    end
  end

  assign cfg = cfgReg;

endmodule

// ==== arbiter/portArbiter.sv ====
module portArbiter
  import nocPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  arbCfg_t              cfg,
  input  logic [NUM_PORTS-1:0] qValid,
  input  flit_t                qFlit [NUM_PORTS],
  output logic [NUM_PORTS-1:0] qReady,
  input  logic [NUM_PORTS-1:0] timesUp,
  output logic [NUM_PORTS-1:0] holdRun,
  output logic [NUM_PORTS-1:0] holdClear,
  output logic [NUM_PORTS-1:0] headSeen,
  output logic [HOLD_W-1:0]    headLength,
  output logic                 outValid,
  output outFlit_t             outFlit,
  input  logic                 outReady
);

  arbState_t state;
  arbState_t nextState;
  logic newGrant;
  logic [NUM_PORTS-1:0] req;
  logic [NUM_PORTS-1:0] grantVec;
  portId_t gntIdx;
  flit_t gntFlit;
  logic xfer;
  logic tailXfer;

  // First requester after start, start itself checked last
  function automatic arbState_t pickNext(logic [NUM_PORTS-1:0] reqs, int start);
    arbState_t pick;
    int idx;
    logic found;
    pick = IDLE;
    found = 1'b0;
    for (int i = 1; i <= NUM_PORTS; i++)
    begin
      idx = (start + i) % NUM_PORTS;
      if (!found && reqs[idx])
      begin
        pick = arbState_t'(STATE_W'(1) << (idx + 1));
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  assign req = qValid & cfg.portMask;
  assign grantVec = state[NUM_PORTS:1];

  always_comb
  begin
    gntIdx = PORT_L;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (grantVec[p])
        gntIdx = portId_t'(p);
    end
  end

  // ####################
  // Output mux
  // ####################

  assign gntFlit = qFlit[gntIdx];
  assign qReady = grantVec & cfg.portMask & ~timesUp & {NUM_PORTS{outReady}};
  assign outValid = (state != IDLE) && req[gntIdx] && !timesUp[gntIdx];
  assign outFlit = '{flit: gntFlit, src: gntIdx};
  assign xfer = outValid && outReady;
  assign tailXfer = xfer && (gntFlit.kind == TAIL);

  assign holdRun = qReady & qValid;
  assign headSeen = holdRun & {NUM_PORTS{gntFlit.kind == HEAD}};
  assign headLength = gntFlit.payload[HOLD_W-1:0];
  assign holdClear = newGrant ? nextState[NUM_PORTS:1] : '0;

  // ####################
  // Grant FSM
  // ####################

  always_comb
  begin
    nextState = state;
    newGrant = 1'b0;
    case (state)
      IDLE:
      begin
        if (|req)
        begin
          nextState = pickNext(req, NUM_PORTS - 1);
          newGrant = 1'b1;
        end
      end
      default:
      begin
        // Leave on tail, expiry or loss of request
        if (!req[gntIdx] || timesUp[gntIdx] || tailXfer)
        begin
          if (|req)
          begin
            nextState = pickNext(req, int'(gntIdx));
            newGrant = 1'b1;
          end
          else
            nextState = IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= IDLE;
    else
      state <= nextState;
  end

endmodule

// ==== arbiter/holdTimer.sv ====
module holdTimer
  import nocPkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              headSeen,
  input  logic [HOLD_W-1:0] headLength,
  input  logic [HOLD_W-1:0] maxHold,
  input  logic              holdRun,
  input  logic              holdClear,
  output logic              timesUp
);

  logic [HOLD_W-1:0] limit;
  logic [HOLD_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= DEFAULT_HOLD;
      count <= '0;
    end
    else
    begin
      // Head length capped by the configured maximum
      if (headSeen)
        limit <= (headLength < maxHold) ? headLength : maxHold;
      if (holdClear)
        count <= '0;
      else if (holdRun)
        count <= count + 1'b1;
    end
  end

  assign timesUp = (count == limit);

endmodule

// ==== inputBuffer/flitQueue.sv ====
module flitQueue
  import nocPkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  inValid,
  input  flit_t inFlit,
  output logic  inReady,
  output logic  qValid,
  output flit_t qFlit,
  input  logic  qReady
);

  flit_t mem [QUEUE_DEPTH];
  logic [QPTR_W-1:0] wrPtr;
  logic [QPTR_W-1:0] rdPtr;
  logic [QPTR_W:0] count;
  logic [QPTR_W:0] countNext;
  logic push;
  logic pop;

  assign push = inValid && inReady;
  assign pop = qValid && qReady;
  assign countNext = count + (QPTR_W + 1)'(push) - (QPTR_W + 1)'(pop);

  // Head is read straight from storage, no fall-through
  assign qValid = (count != '0);
  assign qFlit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      inReady <= 1'b1;
    end
    else
    begin
      if (push)
        wrPtr <= wrPtr + 1'b1;
      if (pop)
        rdPtr <= rdPtr + 1'b1;
      count <= countNext;
      inReady <= (countNext != QUEUE_DEPTH);
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

endmodule

// ==== common/nocPkg.sv ====
package nocPkg;

  // ####################
  // Sizes
  // ####################

  localparam int NUM_PORTS = 5;
  localparam int QUEUE_DEPTH = 4;
  localparam int QPTR_W = $clog2(QUEUE_DEPTH);
  localparam int PAYLOAD_W = 16;
  localparam int HOLD_W = 8;
  localparam int STATE_W = NUM_PORTS + 1;
  localparam logic [HOLD_W-1:0] DEFAULT_HOLD = 8'd8;

  // ####################
  // Flits and ports
  // ####################

  typedef enum logic [2:0] {
    BODY = 3'b000,
    HEAD = 3'b001,
    TAIL = 3'b010
  } flitKind_t;

  // Head flits carry the hold length in payload[7:0]
  typedef struct packed {
    flitKind_t kind;
    logic [PAYLOAD_W-1:0] payload;
  } flit_t;

  typedef enum logic [2:0] {
    PORT_L,
    PORT_N,
    PORT_E,
    PORT_W,
    PORT_S
  } portId_t;

  typedef struct packed {
    flit_t flit;
    portId_t src;
  } outFlit_t;

  // One-hot grant states, bit p+1 is the grant of port p
  typedef enum logic [STATE_W-1:0] {
    IDLE    = 6'b000001,
    GRANT_L = 6'b000010,
    GRANT_N = 6'b000100,
    GRANT_E = 6'b001000,
    GRANT_W = 6'b010000,
    GRANT_S = 6'b100000
  } arbState_t;

  typedef struct packed {
    logic [NUM_PORTS-1:0] portMask;
    logic [HOLD_W-1:0] maxHold;
  } arbCfg_t;

  typedef enum logic {
    CFG_MASK,
    CFG_HOLD
  } cfgAddr_t;

endpackage
